// File: audio_combiner.sv
// Adds tape audio to the stereo mix and drives one first-order sigma-delta DAC per channel
`timescale 1ns/100ps

module audio_combiner
	import telestrat_pkg::*;
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [SAMPLE_W-1:0] psg_l_i,
	input  logic [SAMPLE_W-1:0] psg_r_i,
	input  logic                tape_bit_i,
	input  tape_volume_e        tape_volume_i,
	output logic [SAMPLE_W-1:0] sample_l_o,
	output logic [SAMPLE_W-1:0] sample_r_o,
	output logic                audio_l_o,
	output logic                audio_r_o
);

	logic [7:0]          tape_step;
	logic [7:0]          tape_level;
	logic [SAMPLE_W-1:0] psg_in [2];
	logic [SAMPLE_W-1:0] sample [2];
	logic [SAMPLE_W-1:0] acc [2];
	logic                dac_bit [2];

	// ==================================================
	// Tape audio level
	// ==================================================
	always_comb begin
		case (tape_volume_i)
			MUTE:    tape_step = 8'd0;
			LOW:     tape_step = 8'd64;
			default: tape_step = 8'd128;
		endcase
	end

	assign tape_level = tape_bit_i ? tape_step : 8'd0;

	// Channel 0 is left, channel 1 is right
	assign psg_in[0] = psg_l_i;
	assign psg_in[1] = psg_r_i;

	// ==================================================
	// Sample register and sigma-delta DAC per channel
	// ==================================================
	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		logic [SAMPLE_W:0] acc_sum;

		// Carry out of the accumulator is the pulse density
		assign acc_sum = {1'b0, acc[ch]} + {1'b0, sample[ch]};

		always_ff @(posedge clk_sys) begin
			if (reset) begin
				sample[ch]  <= '0;
				acc[ch]     <= '0;
				dac_bit[ch] <= 1'b0;
			end else begin
				// Wraps modulo 2^16
				sample[ch]  <= psg_in[ch] + SAMPLE_W'(tape_level);
				acc[ch]     <= acc_sum[SAMPLE_W-1:0];
				dac_bit[ch] <= acc_sum[SAMPLE_W];
			end
		end
	end

	assign sample_l_o = sample[0];
	assign sample_r_o = sample[1];
	assign audio_l_o  = dac_bit[0];
	assign audio_r_o  = dac_bit[1];

endmodule

// File: cassette_player.sv
// Plays the cached tape image as a serial bit stream while the motor relay is on
`timescale 1ns/100ps

module cassette_player
	import telestrat_pkg::*;
#(
	parameter int BIT_PERIOD = 24
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   rewind_i,
	input  logic                   load_active_i,
	input  logic                   relay_i,
	input  logic                   use_adc_i,
	input  logic                   adc_i,
	input  logic                   loaded_i,
	input  logic [TAPE_ADDR_W-1:0] tape_end_i,
	output logic [TAPE_ADDR_W-1:0] rd_addr_o,
	input  logic [7:0]             rd_data_i,
	output logic                   tape_bit_o
);

	localparam int CNT_W = (BIT_PERIOD > 1) ? $clog2(BIT_PERIOD) : 1;

	player_state_e          state;
	logic [TAPE_ADDR_W-1:0] addr;
	logic [CNT_W-1:0]       cnt;
	logic [2:0]             bit_idx;
	logic [7:0]             shreg;
	logic                   last_byte;
	logic                   enable;
	logic                   restart;
	logic                   bit_end;
	logic                   byte_end;
	logic                   load_byte;
	logic                   player_bit;

	assign enable    = relay_i & loaded_i & ~use_adc_i;
	assign restart   = rewind_i | load_active_i;
	assign bit_end   = (cnt == CNT_W'(BIT_PERIOD - 1));
	assign byte_end  = (state == SHIFT) && bit_end && (bit_idx == 3'd7);
	// First byte after FETCH, later bytes back to back
	assign load_byte = (state == FETCH) || (byte_end && !last_byte);

	// The cache reads this address every cycle, so the next byte is ready early
	assign rd_addr_o = addr;

	// ==================================================
	// Playback FSM
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || restart) begin
			state     <= IDLE;
			addr      <= '0;
			cnt       <= '0;
			bit_idx   <= '0;
			last_byte <= 1'b0;
		end else if (enable) begin
			if (load_byte) begin
				addr      <= addr + 1'b1;
				last_byte <= (addr == tape_end_i);
			end
			case (state)
				IDLE: state <= FETCH;
				FETCH: begin
					state   <= SHIFT;
					cnt     <= '0;
					bit_idx <= '0;
				end
				SHIFT: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (byte_end && last_byte) begin
							state <= DONE;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= DONE;
			endcase
		end
	end

	// MSB first
	always_ff @(posedge clk_sys) begin
		if (enable && load_byte) begin
			shreg <= rd_data_i;
		end else if (enable && (state == SHIFT) && bit_end) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	assign player_bit = (state == SHIFT) & shreg[7];

	// ADC level bypasses the file
	assign tape_bit_o = use_adc_i ? adc_i : player_bit;

endmodule

// File: psg_stereo_mix.sv
// Registered left and right sums of the three sound channels for the selected stereo mode
`timescale 1ns/100ps

module psg_stereo_mix
	import telestrat_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [PSG_W-1:0]     psg_a_i,
	input  logic [PSG_W-1:0]     psg_b_i,
	input  logic [PSG_W-1:0]     psg_c_i,
	input  logic [PSG_MIX_W-1:0] psg_mix_i,
	input  stereo_mode_e         stereo_mode_i,
	output logic [SAMPLE_W-1:0]  left_o,
	output logic [SAMPLE_W-1:0]  right_o
);

	logic [PSG_W:0]      sum_ab;
	logic [PSG_W:0]      sum_ac;
	logic [PSG_W:0]      sum_bc;
	logic [SAMPLE_W-1:0] mono;
	logic [SAMPLE_W-1:0] left_d;
	logic [SAMPLE_W-1:0] right_d;

	// Pair sums keep the carry
	assign sum_ab = {1'b0, psg_a_i} + {1'b0, psg_b_i};
	assign sum_ac = {1'b0, psg_a_i} + {1'b0, psg_c_i};
	assign sum_bc = {1'b0, psg_b_i} + {1'b0, psg_c_i};

	assign mono = {psg_mix_i, 2'b00};

	always_comb begin
		case (stereo_mode_i)
			OFF: begin
				left_d  = mono;
				right_d = mono;
			end
			ABC: begin
				left_d  = {sum_ab, 3'b000};
				right_d = {sum_bc, 3'b000};
			end
			// ACB and the spare code
			default: begin
				left_d  = {sum_ac, 3'b000};
				right_d = {sum_ab, 3'b000};
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			left_o  <= '0;
			right_o <= '0;
		end else begin
			left_o  <= left_d;
			right_o <= right_d;
		end
	end

endmodule

// File: src.f
telestrat_pkg.sv
tape_cache.sv
cassette_player.sv
psg_stereo_mix.sv
audio_combiner.sv
telestrat_audio_top.sv
telestrat_audio_chk.sv
tb_telestrat_audio.sv

// File: tape_cache.sv
// Tape image RAM, written from the download stream and read back by the cassette player
`timescale 1ns/100ps

module tape_cache
	import telestrat_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [TAPE_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]             ioctl_dout_i,
	input  logic [TAPE_ADDR_W-1:0] rd_addr_i,
	output logic [7:0]             rd_data_o,
	output logic [TAPE_ADDR_W-1:0] tape_end_o,
	output logic                   loaded_o,
	output logic                   load_active_o
);

	logic [7:0] mem [2**TAPE_ADDR_W];

	logic                   load_tape;
	logic                   load_d;
	logic [TAPE_ADDR_W-1:0] mem_addr;

	// Tape file when the low index bits match
	assign load_tape = ioctl_download_i && (ioctl_index_i[4:0] == TAPE_INDEX[4:0]);

	// Download owns the RAM port during a load
	assign mem_addr = load_tape ? ioctl_addr_i : rd_addr_i;

	always_ff @(posedge clk_sys) begin
		if (load_tape && ioctl_wr_i) begin
			mem[mem_addr] <= ioctl_dout_i;
		end
		rd_data_o <= mem[mem_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_d     <= 1'b0;
			loaded_o   <= 1'b0;
			tape_end_o <= '0;
		end else begin
			load_d <= load_tape;
			// Sticky until reset
			if (load_tape && !load_d) begin
				loaded_o <= 1'b1;
			end
			// Last byte written so far
			if (load_tape && ioctl_wr_i) begin
				tape_end_o <= ioctl_addr_i;
			end
		end
	end

	assign load_active_o = load_tape;

endmodule

// File: tb_telestrat_audio.sv
// Testbench for the audio and tape top level that drives the mixer, ADC bypass, tape playback and DACs
`timescale 1ns/100ps

module tb_telestrat_audio
	import telestrat_pkg::*;
();

	localparam int BIT_PERIOD = 4;
	localparam int NUM_BYTES  = 6;
	localparam int STREAM_END = 2 + NUM_BYTES * 8 * BIT_PERIOD;

	logic                   clk_sys;
	logic                   reset;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [TAPE_ADDR_W-1:0] ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic                   tape_rewind;
	logic                   cas_relay;
	logic                   tape_use_adc;
	logic                   tape_adc;
	tape_volume_e           tape_volume;
	stereo_mode_e           stereo_mode;
	logic [PSG_W-1:0]       psg_a;
	logic [PSG_W-1:0]       psg_b;
	logic [PSG_W-1:0]       psg_c;
	logic [PSG_MIX_W-1:0]   psg_mix;
	logic                   tape_bit_o;
	logic                   tape_loaded_o;
	logic [SAMPLE_W-1:0]    sample_l_o;
	logic [SAMPLE_W-1:0]    sample_r_o;
	logic                   audio_l_o;
	logic                   audio_r_o;

	integer     seed;
	logic [7:0] tape_bytes [NUM_BYTES];

	telestrat_audio_top #(
		.BIT_PERIOD (BIT_PERIOD)
	) i_telestrat_audio_top (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download),
		.ioctl_index_i    (ioctl_index),
		.ioctl_wr_i       (ioctl_wr),
		.ioctl_addr_i     (ioctl_addr),
		.ioctl_dout_i     (ioctl_dout),
		.tape_rewind_i    (tape_rewind),
		.cas_relay_i      (cas_relay),
		.tape_use_adc_i   (tape_use_adc),
		.tape_adc_i       (tape_adc),
		.tape_volume_i    (tape_volume),
		.stereo_mode_i    (stereo_mode),
		.psg_a_i          (psg_a),
		.psg_b_i          (psg_b),
		.psg_c_i          (psg_c),
		.psg_mix_i        (psg_mix),
		.tape_bit_o       (tape_bit_o),
		.tape_loaded_o    (tape_loaded_o),
		.sample_l_o       (sample_l_o),
		.sample_r_o       (sample_r_o),
		.audio_l_o        (audio_l_o),
		.audio_r_o        (audio_r_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Reporting
	// ==================================================
	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic value_error(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		fail_run();
	endtask

	task automatic timeout_error(input string what);
		$display("Timed out while waiting for %s", what);
		fail_run();
	endtask

	always @(negedge clk_sys) begin
		if (i_telestrat_audio_top.i_audio_chk.fail_count != 0) begin
			$display("A concurrent assertion in the checker failed");
			fail_run();
		end
	end

	// ==================================================
	// Reference model
	// ==================================================
	function automatic void mix_model(input int mode, input logic [PSG_W-1:0] a,
		input logic [PSG_W-1:0] b, input logic [PSG_W-1:0] c,
		input logic [PSG_MIX_W-1:0] mix, output logic [SAMPLE_W-1:0] l,
		output logic [SAMPLE_W-1:0] r);
		int ab;
		int ac;
		int bc;
		ab = a + b;
		ac = a + c;
		bc = b + c;
		if (mode == 0) begin
			l = SAMPLE_W'(mix * 4);
			r = SAMPLE_W'(mix * 4);
		end else if (mode == 1) begin
			l = SAMPLE_W'(ab * 8);
			r = SAMPLE_W'(bc * 8);
		end else begin
			l = SAMPLE_W'(ac * 8);
			r = SAMPLE_W'(ab * 8);
		end
	endfunction

	function automatic int volume_level(input int vol);
		if (vol == 0) return 0;
		if (vol == 1) return 64;
		return 128;
	endfunction

	// pos counts enabled cycles since relay-on
	function automatic logic expected_tape_bit(input int pos);
		int idx;
		if (pos < 2) return 1'b0;
		idx = (pos - 2) / BIT_PERIOD;
		if (idx >= NUM_BYTES * 8) return 1'b0;
		return tape_bytes[idx / 8][7 - (idx % 8)];
	endfunction

	// ==================================================
	// Stimulus helpers
	// ==================================================
	task automatic download_tape();
		ioctl_download = 1'b1;
		ioctl_index    = 8'h01;
		for (int i = 0; i < NUM_BYTES; i++) begin
			@(negedge clk_sys);
			ioctl_addr = TAPE_ADDR_W'(i);
			ioctl_dout = tape_bytes[i];
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	// Relay on until pos reaches stop_pos with an optional relay-off gap
	task automatic run_tape(input int stop_pos, input int freeze_at, input int freeze_len);
		int   pos;
		int   cycles;
		int   frozen;
		logic exp_bit;
		pos       = 0;
		cycles    = 0;
		frozen    = 0;
		cas_relay = 1'b1;
		while (pos < stop_pos) begin
			@(negedge clk_sys);
			if (cas_relay) pos++;
			cycles++;
			exp_bit = expected_tape_bit(pos);
			assert (tape_bit_o == exp_bit)
			else value_error($sformatf("tape bit %0b at stream cycle %0d, expected %0b",
				tape_bit_o, pos, exp_bit));
			if (cycles > stop_pos + freeze_len + 20) timeout_error("the tape stream");
			if (pos == freeze_at && cas_relay) begin
				cas_relay = 1'b0;
			end else if (!cas_relay) begin
				frozen++;
				if (frozen >= freeze_len) cas_relay = 1'b1;
			end
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		logic [SAMPLE_W-1:0] q_l [$];
		logic [SAMPLE_W-1:0] q_r [$];
		logic [SAMPLE_W-1:0] exp_l;
		logic [SAMPLE_W-1:0] exp_r;
		logic [SAMPLE_W-1:0] base_l;
		logic [SAMPLE_W-1:0] base_r;
		logic                prev_adc;
		int                  prev_vol;
		int                  cycles;
		int                  s_val;
		int                  ones_l;
		int                  ones_r;

		seed           = 32'hc4c8;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'h00;
		tape_rewind    = 1'b0;
		cas_relay      = 1'b0;
		tape_use_adc   = 1'b0;
		tape_adc       = 1'b0;
		tape_volume    = MUTE;
		stereo_mode    = OFF;
		psg_a          = '0;
		psg_b          = '0;
		psg_c          = '0;
		psg_mix        = '0;
		for (int i = 0; i < NUM_BYTES; i++) tape_bytes[i] = $random(seed);
		// Byte 1 opens with a one so the rewind is visible
		tape_bytes[1] = tape_bytes[1] | 8'h80;
		// The bit held during the relay pause is a one
		tape_bytes[2] = tape_bytes[2] | 8'h08;

		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		assert (!tape_bit_o && !tape_loaded_o && sample_l_o == '0 && sample_r_o == '0 &&
			!audio_l_o && !audio_r_o)
		else value_error("outputs not zero after reset");

		// Stereo modes through the two-cycle pipeline
		q_l = '{16'h0, 16'h0};
		q_r = '{16'h0, 16'h0};
		for (int m = 0; m < 4; m++) begin
			repeat (16) begin
				exp_l = q_l.pop_front();
				exp_r = q_r.pop_front();
				assert (sample_l_o == exp_l && sample_r_o == exp_r)
				else value_error($sformatf("samples %h/%h, expected %h/%h",
					sample_l_o, sample_r_o, exp_l, exp_r));
				stereo_mode = stereo_mode_e'(m);
				psg_a       = $random(seed);
				psg_b       = $random(seed);
				psg_c       = $random(seed);
				psg_mix     = $random(seed);
				mix_model(m, psg_a, psg_b, psg_c, psg_mix, exp_l, exp_r);
				q_l.push_back(exp_l);
				q_r.push_back(exp_r);
				@(negedge clk_sys);
			end
		end

		// ADC bypass and tape volume
		stereo_mode  = OFF;
		psg_mix      = $random(seed);
		tape_use_adc = 1'b1;
		tape_adc     = 1'b0;
		tape_volume  = MUTE;
		repeat (3) @(negedge clk_sys);
		mix_model(0, psg_a, psg_b, psg_c, psg_mix, base_l, base_r);
		prev_adc = 1'b0;
		prev_vol = 0;
		repeat (40) begin
			exp_l = base_l + SAMPLE_W'(prev_adc ? volume_level(prev_vol) : 0);
			exp_r = base_r + SAMPLE_W'(prev_adc ? volume_level(prev_vol) : 0);
			assert (tape_bit_o == prev_adc)
			else value_error($sformatf("tape bit %0b, ADC level %0b", tape_bit_o, prev_adc));
			assert (sample_l_o == exp_l && sample_r_o == exp_r)
			else value_error($sformatf("tape samples %h/%h, expected %h/%h",
				sample_l_o, sample_r_o, exp_l, exp_r));
			tape_adc    = $random(seed);
			tape_volume = tape_volume_e'($random(seed) & 3);
			prev_adc    = tape_adc;
			prev_vol    = tape_volume;
			@(negedge clk_sys);
		end
		tape_use_adc = 1'b0;
		tape_adc     = 1'b0;
		tape_volume  = MUTE;

		// Tape download and playback with a relay pause mid-byte
		download_tape();
		cycles = 0;
		while (!tape_loaded_o) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > 20) timeout_error("the tape loaded flag");
		end
		run_tape(STREAM_END + 16, 2 + 20 * BIT_PERIOD + 1, 7);
		cas_relay   = 1'b0;
		tape_rewind = 1'b1;
		@(negedge clk_sys);
		tape_rewind = 1'b0;

		// Rewind while the first bit of byte 1 is playing
		run_tape(2 + 8 * BIT_PERIOD + 2, -1, 0);
		tape_rewind = 1'b1;
		@(negedge clk_sys);
		tape_rewind = 1'b0;
		cas_relay   = 1'b0;
		repeat (3) begin
			assert (tape_bit_o == 1'b0)
			else value_error("tape bit not cleared by rewind");
			@(negedge clk_sys);
		end
		run_tape(STREAM_END + 8, -1, 0);
		cas_relay = 1'b0;

		// Sigma-delta density over one full accumulator period
		stereo_mode = OFF;
		psg_mix     = $random(seed);
		s_val       = psg_mix * 4;
		repeat (3) @(negedge clk_sys);
		ones_l = 0;
		ones_r = 0;
		repeat (65536) begin
			@(negedge clk_sys);
			ones_l += audio_l_o;
			ones_r += audio_r_o;
		end
		assert (ones_l >= s_val - 1 && ones_l <= s_val + 1 &&
			ones_r >= s_val - 1 && ones_r <= s_val + 1)
		else value_error($sformatf("DAC ones %0d/%0d, expected %0d", ones_l, ones_r, s_val));

		if (i_telestrat_audio_top.i_audio_chk.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

// File: telestrat_audio_chk.sv
// Concurrent checks on reset values, ADC bypass and mixer latency for binding into the audio top level
`timescale 1ns/100ps

module telestrat_audio_chk
	import telestrat_pkg::*;
(
	input logic                 clk_sys,
	input logic                 reset,
	input logic                 tape_use_adc_i,
	input logic                 tape_adc_i,
	input tape_volume_e         tape_volume_i,
	input stereo_mode_e         stereo_mode_i,
	input logic [PSG_MIX_W-1:0] psg_mix_i,
	input logic                 tape_bit_o,
	input logic                 tape_loaded_o,
	input logic [SAMPLE_W-1:0]  sample_l_o,
	input logic [SAMPLE_W-1:0]  sample_r_o,
	input logic                 audio_l_o,
	input logic                 audio_r_o
);

	int unsigned fail_count = 0;

	// ==================================================
	// Reset and tape bit
	// ==================================================
	a_reset_values: assert property (@(posedge clk_sys)
		reset |=> (!tape_loaded_o && sample_l_o == '0 && sample_r_o == '0 &&
			!audio_l_o && !audio_r_o && (tape_use_adc_i || !tape_bit_o)))
	else begin
		fail_count++;
		$error("Outputs not cleared by reset");
	end

	// Bypass is combinational
	a_adc_bypass: assert property (@(posedge clk_sys) disable iff (reset)
		tape_use_adc_i |-> (tape_bit_o == tape_adc_i))
	else begin
		fail_count++;
		$error("Tape bit does not follow the ADC level");
	end

	// ==================================================
	// Mono mix reaches both samples two cycles later
	// ==================================================
	a_off_latency_l: assert property (@(posedge clk_sys) disable iff (reset)
		(stereo_mode_i == OFF) ##1 (tape_volume_i == MUTE) |=>
		(sample_l_o == SAMPLE_W'($past(psg_mix_i, 2) * 4)))
	else begin
		fail_count++;
		$error("Left sample is not the mono mix after two cycles");
	end

	a_off_latency_r: assert property (@(posedge clk_sys) disable iff (reset)
		(stereo_mode_i == OFF) ##1 (tape_volume_i == MUTE) |=>
		(sample_r_o == SAMPLE_W'($past(psg_mix_i, 2) * 4)))
	else begin
		fail_count++;
		$error("Right sample is not the mono mix after two cycles");
	end

endmodule

bind telestrat_audio_top telestrat_audio_chk i_audio_chk (.*);

// File: telestrat_audio_top.sv
// Top level of the audio and tape section, wiring tape path, stereo mixer and DAC combiner
`timescale 1ns/100ps

module telestrat_audio_top
	import telestrat_pkg::*;
#(
	parameter int BIT_PERIOD = 24
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  logic [TAPE_ADDR_W-1:0] ioctl_addr_i,
	input  logic [7:0]             ioctl_dout_i,
	input  logic                   tape_rewind_i,
	input  logic                   cas_relay_i,
	input  logic                   tape_use_adc_i,
	input  logic                   tape_adc_i,
	input  tape_volume_e           tape_volume_i,
	input  stereo_mode_e           stereo_mode_i,
	input  logic [PSG_W-1:0]       psg_a_i,
	input  logic [PSG_W-1:0]       psg_b_i,
	input  logic [PSG_W-1:0]       psg_c_i,
	input  logic [PSG_MIX_W-1:0]   psg_mix_i,
	output logic                   tape_bit_o,
	output logic                   tape_loaded_o,
	output logic [SAMPLE_W-1:0]    sample_l_o,
	output logic [SAMPLE_W-1:0]    sample_r_o,
	output logic                   audio_l_o,
	output logic                   audio_r_o
);

	logic [TAPE_ADDR_W-1:0] tape_rd_addr;
	logic [7:0]             tape_rd_data;
	logic [TAPE_ADDR_W-1:0] tape_end;
	logic                   tape_load_active;
	logic [SAMPLE_W-1:0]    psg_l;
	logic [SAMPLE_W-1:0]    psg_r;

	// ==================================================
	// Tape path
	// ==================================================
	tape_cache i_tape_cache (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.rd_addr_i        (tape_rd_addr),
		.rd_data_o        (tape_rd_data),
		.tape_end_o       (tape_end),
		.loaded_o         (tape_loaded_o),
		.load_active_o    (tape_load_active)
	);

	cassette_player #(
		.BIT_PERIOD (BIT_PERIOD)
	) i_cassette_player (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rewind_i      (tape_rewind_i),
		.load_active_i (tape_load_active),
		.relay_i       (cas_relay_i),
		.use_adc_i     (tape_use_adc_i),
		.adc_i         (tape_adc_i),
		.loaded_i      (tape_loaded_o),
		.tape_end_i    (tape_end),
		.rd_addr_o     (tape_rd_addr),
		.rd_data_i     (tape_rd_data),
		.tape_bit_o    (tape_bit_o)
	);

	// ==================================================
	// Stereo mix and DACs
	// ==================================================
	psg_stereo_mix i_psg_stereo_mix (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.psg_a_i       (psg_a_i),
		.psg_b_i       (psg_b_i),
		.psg_c_i       (psg_c_i),
		.psg_mix_i     (psg_mix_i),
		.stereo_mode_i (stereo_mode_i),
		.left_o        (psg_l),
		.right_o       (psg_r)
	);

	audio_combiner i_audio_combiner (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.psg_l_i       (psg_l),
		.psg_r_i       (psg_r),
		.tape_bit_i    (tape_bit_o),
		.tape_volume_i (tape_volume_i),
		.sample_l_o    (sample_l_o),
		.sample_r_o    (sample_r_o),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o)
	);

endmodule

// File: telestrat_pkg.sv
// Shared widths, the tape download index and the enum types for the audio and tape design
package telestrat_pkg;

	// ==================================================
	// Audio widths
	// ==================================================

	// One sound-generator channel
	localparam int PSG_W = 12;

	// Mono mix from the sound generator
	localparam int PSG_MIX_W = 14;

	// DAC sample, also the sigma-delta accumulator width
	localparam int SAMPLE_W = 16;

	// ==================================================
	// Tape cache
	// ==================================================

	// 64 KiB of tape image
	localparam int TAPE_ADDR_W = 16;

	// Download index of a tape file, low five bits compared
	localparam logic [7:0] TAPE_INDEX = 8'd1;

	// ==================================================
	// Mode and state encodings
	// ==================================================

	// Value 3 is treated as ACB
	typedef enum logic [1:0] {
		OFF = 2'd0,
		ABC = 2'd1,
		ACB = 2'd2
	} stereo_mode_e;

	// Value 3 is treated as HIGH
	typedef enum logic [1:0] {
		MUTE = 2'd0,
		LOW  = 2'd1,
		HIGH = 2'd2
	} tape_volume_e;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		SHIFT = 2'd2,
		DONE  = 2'd3
	} player_state_e;

endpackage
